// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_layer_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hdl/conv_geometry_pkg.sv
hdl/conv_format_pkg.sv
hdl/conv_line_buffer.sv
hdl/conv_weight_store.sv
hdl/conv_mac_array.sv
hdl/conv_output_serializer.sv
hdl/conv_layer_top.sv
verification/conv_layer_checker.sv
verification/conv_layer_tb.sv

// ==== hdl/conv_format_pkg.sv ====
package conv_format_pkg;

	//////////////////////////////
	// Word widths
	//////////////////////////////
	localparam int PIXEL_WIDTH   = 8;
	localparam int WEIGHT_WIDTH  = 8;
	localparam int PRODUCT_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;
	// Holds 18 full-scale products without wrapping
	localparam int SUM_WIDTH     = 20;

	typedef logic signed [PIXEL_WIDTH-1:0]   pixel_t;
	typedef logic signed [WEIGHT_WIDTH-1:0]  weight_t;
	typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
	typedef logic signed [SUM_WIDTH-1:0]     sum_t;

	//////////////////////////////
	// Bundles
	//////////////////////////////
	// Taps per input channel, row 0 is the oldest row, column 0 the leftmost
	typedef struct packed {
		pixel_t [conv_geometry_pkg::CHANNEL_NUM_IN-1:0][conv_geometry_pkg::KERNEL-1:0]
			[conv_geometry_pkg::KERNEL-1:0] px;
	} window_t;

	// Kernel set, flat load order maps straight onto this layout
	typedef struct packed {
		weight_t [conv_geometry_pkg::CHANNEL_NUM_OUT-1:0][conv_geometry_pkg::CHANNEL_NUM_IN-1:0]
			[conv_geometry_pkg::KERNEL-1:0][conv_geometry_pkg::KERNEL-1:0] w;
	} weight_set_t;

	// One sum per output channel
	typedef struct packed {
		sum_t [conv_geometry_pkg::CHANNEL_NUM_OUT-1:0] ch;
	} sum_vec_t;

endpackage

// ==== hdl/conv_geometry_pkg.sv ====
package conv_geometry_pkg;

	//////////////////////////////
	// Layer geometry
	//////////////////////////////
	localparam int IMAGE_WIDTH     = 6;
	localparam int IMAGE_HEIGHT    = 6;
	localparam int KERNEL          = 3;
	localparam int CHANNEL_NUM_IN  = 2;
	localparam int CHANNEL_NUM_OUT = 2;
	localparam int WEIGHT_COUNT    = CHANNEL_NUM_OUT * CHANNEL_NUM_IN * KERNEL * KERNEL;

	// Output queue depth, power of two so the pointers wrap by themselves
	localparam int FIFO_DEPTH      = 4;

	//////////////////////////////
	// Counters and indices
	//////////////////////////////
	typedef logic [$clog2(IMAGE_WIDTH)-1:0]     col_t;
	typedef logic [$clog2(IMAGE_HEIGHT)-1:0]    row_t;
	typedef logic [$clog2(CHANNEL_NUM_IN)-1:0]  chan_in_t;
	typedef logic [$clog2(CHANNEL_NUM_OUT)-1:0] chan_out_t;
	typedef logic [$clog2(WEIGHT_COUNT)-1:0]    weight_idx_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0]      fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_count_t;

endpackage

// ==== hdl/conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     weight_valid,
	input  conv_format_pkg::weight_t weight_data,
	input  logic                     pixel_valid,
	input  conv_format_pkg::pixel_t  pixel_data,
	output logic                     weights_loaded,
	output conv_format_pkg::sum_t    pxl_out,
	output logic                     valid_out
);
	import conv_format_pkg::*;

	weight_set_t weight_set;
	window_t     window;
	logic        window_valid;
	sum_vec_t    sums;
	logic        sums_valid;

	//////////////////////////////
	// Kernel configuration
	//////////////////////////////
	conv_weight_store inst_weights (
		.clk           (clk           ),
		.reset         (reset         ),
		.weight_valid  (weight_valid  ),
		.weight_data   (weight_data   ),
		.weight_set    (weight_set    ),
		.weights_loaded(weights_loaded)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////
	conv_line_buffer inst_lines (
		.clk           (clk           ),
		.reset         (reset         ),
		.weights_loaded(weights_loaded),
		.pixel_valid   (pixel_valid   ),
		.pixel_data    (pixel_data    ),
		.window        (window        ),
		.window_valid  (window_valid  )
	);

	conv_mac_array inst_mac (
		.clk         (clk         ),
		.reset       (reset       ),
		.window      (window      ),
		.window_valid(window_valid),
		.weight_set  (weight_set  ),
		.sums        (sums        ),
		.sums_valid  (sums_valid  )
	);

	// Channel sums back onto one stream
	conv_output_serializer inst_serial (
		.clk       (clk       ),
		.reset     (reset     ),
		.sums      (sums      ),
		.sums_valid(sums_valid),
		.pxl_out   (pxl_out   ),
		.valid_out (valid_out )
	);

endmodule

// ==== hdl/conv_line_buffer.sv ====
`timescale 1ns/1ps

module conv_line_buffer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     weights_loaded,
	input  logic                     pixel_valid,
	input  conv_format_pkg::pixel_t  pixel_data,
	output conv_format_pkg::window_t window,
	output logic                     window_valid
);
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	chan_in_t chan;
	col_t     col;
	row_t     row;
	logic     pixel_en;
	logic     last_chan;
	logic     last_col;
	logic     last_row;
	logic     in_image;

	// Previous two rows of each channel indexed by column
	pixel_t line_prev [CHANNEL_NUM_IN][IMAGE_WIDTH];
	pixel_t line_old  [CHANNEL_NUM_IN][IMAGE_WIDTH];

	// Pixels count only once the kernel set is in place
	assign pixel_en  = pixel_valid && weights_loaded;
	assign last_chan = (chan == chan_in_t'(CHANNEL_NUM_IN - 1));
	assign last_col  = (col == col_t'(IMAGE_WIDTH - 1));
	assign last_row  = (row == row_t'(IMAGE_HEIGHT - 1));
	// No padding so the window must lie inside the image
	assign in_image  = (col >= col_t'(KERNEL - 1)) && (row >= row_t'(KERNEL - 1));

	//////////////////////////////
	// Position counters
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			chan <= '0;
			col  <= '0;
			row  <= '0;
		end else if (pixel_en) begin
			if (last_chan) begin
				chan <= '0;
				if (last_col) begin
					col <= '0;
					// Wrap to the next frame
					row <= last_row ? '0 : row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end else begin
				chan <= chan + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Line memories and window
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (pixel_en) begin
			// Shift this channel's taps one column left
			for (int r = 0; r < KERNEL; r++) begin
				for (int k = 0; k < KERNEL - 1; k++) begin
					window.px[chan][r][k] <= window.px[chan][r][k + 1];
				end
			end
			window.px[chan][0][KERNEL-1]        <= line_old[chan][col];
			window.px[chan][1][KERNEL-1]        <= line_prev[chan][col];
			window.px[chan][KERNEL-1][KERNEL-1] <= pixel_data;

			// Every column is rewritten each row, so no stale rows survive a frame
			line_old[chan][col]  <= line_prev[chan][col];
			line_prev[chan][col] <= pixel_data;
		end
	end

	// Pulse after the last channel of an in-image pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			window_valid <= 1'b0;
		end else begin
			window_valid <= pixel_en && last_chan && in_image;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	pixel_after_load: assert property (@(posedge clk) disable iff (reset)
		pixel_valid |-> weights_loaded)
		else $error("pixel strobe arrived before the kernel set was loaded");

	counters_in_range: assert property (@(posedge clk) disable iff (reset)
		(col < col_t'(IMAGE_WIDTH)) && (row < row_t'(IMAGE_HEIGHT)))
		else $error("position counters left the image");

endmodule

// ==== hdl/conv_mac_array.sv ====
`timescale 1ns/1ps

module conv_mac_array (
	input  logic                         clk,
	input  logic                         reset,
	input  conv_format_pkg::window_t     window,
	input  logic                         window_valid,
	input  conv_format_pkg::weight_set_t weight_set,
	output conv_format_pkg::sum_vec_t    sums,
	output logic                         sums_valid
);
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	product_t prod [CHANNEL_NUM_OUT][CHANNEL_NUM_IN][KERNEL][KERNEL];
	logic     prod_valid;
	sum_vec_t sum_next;

	//////////////////////////////
	// Stage 1, products
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (window_valid) begin
			for (int o = 0; o < CHANNEL_NUM_OUT; o++) begin
				for (int i = 0; i < CHANNEL_NUM_IN; i++) begin
					for (int r = 0; r < KERNEL; r++) begin
						for (int c = 0; c < KERNEL; c++) begin
							prod[o][i][r][c] <= $signed(window.px[i][r][c]) *
								$signed(weight_set.w[o][i][r][c]);
						end
					end
				end
			end
		end
	end

	//////////////////////////////
	// Stage 2, channel sums
	//////////////////////////////
	always_comb begin
		sum_t acc;
		for (int o = 0; o < CHANNEL_NUM_OUT; o++) begin
			acc = '0;
			// Sign extend each product before adding
			for (int i = 0; i < CHANNEL_NUM_IN; i++) begin
				for (int r = 0; r < KERNEL; r++) begin
					for (int c = 0; c < KERNEL; c++) begin
						acc = acc + sum_t'(prod[o][i][r][c]);
					end
				end
			end
			sum_next.ch[o] = acc;
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			sums <= sum_next;
		end
	end

	// Valid travels with the data, back to back windows are fine
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sums_valid <= 1'b0;
		end else begin
			prod_valid <= window_valid;
			sums_valid <= prod_valid;
		end
	end

endmodule

// ==== hdl/conv_output_serializer.sv ====
`timescale 1ns/1ps

module conv_output_serializer (
	input  logic                      clk,
	input  logic                      reset,
	input  conv_format_pkg::sum_vec_t sums,
	input  logic                      sums_valid,
	output conv_format_pkg::sum_t     pxl_out,
	output logic                      valid_out
);
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	sum_vec_t    fifo_mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_count_t count;
	chan_out_t   sel;
	logic        push;
	logic        pop;

	assign push      = sums_valid;
	assign valid_out = (count != '0);
	// Entry retires with its last channel
	assign pop       = valid_out && (sel == chan_out_t'(CHANNEL_NUM_OUT - 1));
	assign pxl_out   = fifo_mem[rd_ptr].ch[sel];

	//////////////////////////////
	// Queue storage
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= sums;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			sel    <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			// Channel select steps on every emitted value
			if (valid_out) sel <= pop ? '0 : sel + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (count != fifo_count_t'(FIFO_DEPTH)))
		else $error("sum vector written into a full queue");

	// An empty queue never leaves a vector half emitted
	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		(count == '0) |-> (sel == '0))
		else $error("channel select advanced with the queue empty");

endmodule

// ==== hdl/conv_weight_store.sv ====
`timescale 1ns/1ps

module conv_weight_store (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         weight_valid,
	input  conv_format_pkg::weight_t     weight_data,
	output conv_format_pkg::weight_set_t weight_set,
	output logic                         weights_loaded
);
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	weight_idx_t                load_idx;
	logic                       load_en;
	// Flat bank in load order, index 0 at the bottom
	weight_t [WEIGHT_COUNT-1:0] bank;

	// Kernel set is frozen once complete
	assign load_en = weight_valid && !weights_loaded;

	//////////////////////////////
	// Load sequencing
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			load_idx       <= '0;
			weights_loaded <= 1'b0;
		end else if (load_en) begin
			load_idx <= load_idx + 1'b1;
			if (load_idx == weight_idx_t'(WEIGHT_COUNT - 1)) begin
				weights_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_en) begin
			bank[load_idx] <= weight_data;
		end
	end

	// Output channel, input channel, row, column order matches the struct layout
	assign weight_set = weight_set_t'(bank);

	no_reload: assert property (@(posedge clk) disable iff (reset)
		weight_valid |-> !weights_loaded)
		else $error("weight strobe after the kernel set was complete");

endmodule

// ==== verification/conv_layer_checker.sv ====
`timescale 1ns/1ps

module conv_layer_checker (
	input logic                     clk,
	input logic                     reset,
	input logic                     weight_valid,
	input conv_format_pkg::weight_t weight_data,
	input logic                     pixel_valid,
	input conv_format_pkg::pixel_t  pixel_data,
	input logic                     weights_loaded,
	input conv_format_pkg::sum_t    pxl_out,
	input logic                     valid_out
);
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	int weights_ref [WEIGHT_COUNT];
	int image [CHANNEL_NUM_IN][IMAGE_HEIGHT][IMAGE_WIDTH];
	int expected_q [$];
	int expected;
	int weight_count = 0;
	int chan = 0;
	int col = 0;
	int row = 0;
	// Read by the testbench top at the end of the run
	int pending = 0;
	int values_seen = 0;
	int value_errors = 0;
	int other_errors = 0;

	// Reference sum for one output channel, window anchored at its top left pixel
	function automatic int window_sum(input int o, input int top, input int left);
		int acc;
		acc = 0;
		for (int i = 0; i < CHANNEL_NUM_IN; i++) begin
			for (int r = 0; r < KERNEL; r++) begin
				for (int c = 0; c < KERNEL; c++) begin
					acc += image[i][top + r][left + c] *
						weights_ref[((o * CHANNEL_NUM_IN + i) * KERNEL + r) * KERNEL + c];
				end
			end
		end
		return acc;
	endfunction

	//////////////////////////////
	// Model and compare
	//////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			weight_count = 0;
			chan = 0;
			col = 0;
			row = 0;
		end else begin
			// Load flag rises exactly after the last weight
			if (weights_loaded != (weight_count == WEIGHT_COUNT)) begin
				other_errors++;
				$display("ERROR at %0t: weights_loaded is %0b after %0d weight strobes",
					$time, weights_loaded, weight_count);
			end
			if (weight_valid && weight_count < WEIGHT_COUNT) begin
				weights_ref[weight_count] = int'(weight_data);
				weight_count++;
			end

			if (pixel_valid) begin
				image[chan][row][col] = int'(pixel_data);
				if (chan == CHANNEL_NUM_IN - 1) begin
					// Only windows fully inside the image give outputs
					if (col >= KERNEL - 1 && row >= KERNEL - 1) begin
						for (int o = 0; o < CHANNEL_NUM_OUT; o++) begin
							expected_q.push_back(window_sum(o, row - KERNEL + 1, col - KERNEL + 1));
						end
					end
					chan = 0;
					if (col == IMAGE_WIDTH - 1) begin
						col = 0;
						row = (row == IMAGE_HEIGHT - 1) ? 0 : row + 1;
					end else begin
						col++;
					end
				end else begin
					chan++;
				end
			end

			if (valid_out) begin
				values_seen++;
				if (expected_q.size() == 0) begin
					other_errors++;
					$display("ERROR at %0t: unexpected valid_out with pxl_out %0d",
						$time, pxl_out);
				end else begin
					expected = expected_q.pop_front();
					if (int'(pxl_out) != expected) begin
						value_errors++;
						$display("ERROR at %0t: pxl_out %0d, expected %0d",
							$time, pxl_out, expected);
					end
				end
			end
			pending = expected_q.size();
		end
	end

endmodule

// ==== verification/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;
	import conv_format_pkg::*;
	import conv_geometry_pkg::*;

	localparam int FRAMES        = 5;
	localparam int FRAME_VALUES  = (IMAGE_WIDTH - KERNEL + 1) * (IMAGE_HEIGHT - KERNEL + 1) *
		CHANNEL_NUM_OUT;
	localparam int LOAD_TIMEOUT  = 100;
	localparam int DRAIN_TIMEOUT = 200;

	logic    clk;
	logic    reset;
	logic    weight_valid;
	weight_t weight_data;
	logic    pixel_valid;
	pixel_t  pixel_data;
	logic    weights_loaded;
	sum_t    pxl_out;
	logic    valid_out;
	int      end_errors;

	always #4 clk = ~clk;

	conv_layer_top conv_layer_top_i (
		.clk           (clk           ),
		.reset         (reset         ),
		.weight_valid  (weight_valid  ),
		.weight_data   (weight_data   ),
		.pixel_valid   (pixel_valid   ),
		.pixel_data    (pixel_data    ),
		.weights_loaded(weights_loaded),
		.pxl_out       (pxl_out       ),
		.valid_out     (valid_out     )
	);

	conv_layer_checker checker_i (.*);

	//////////////////////////////
	// Drive tasks
	//////////////////////////////
	// All tasks start and end 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_weight(input weight_t value);
		weight_valid = 1'b1;
		weight_data  = value;
		idle_cycles(1);
		weight_valid = 1'b0;
	endtask

	task automatic send_pixel(input pixel_t value);
		pixel_valid = 1'b1;
		pixel_data  = value;
		idle_cycles(1);
		pixel_valid = 1'b0;
	endtask

	// One frame of random pixels or a constant fill with optional random gaps
	task automatic send_frame(input bit fixed, input pixel_t fill, input bit gaps);
		pixel_t value;
		for (int n = 0; n < IMAGE_WIDTH * IMAGE_HEIGHT * CHANNEL_NUM_IN; n++) begin
			value = fixed ? fill : pixel_t'($urandom);
			send_pixel(value);
			if (gaps && ($urandom % 4 == 0)) begin
				idle_cycles(int'($urandom % 3) + 1);
			end
		end
	endtask

	task automatic send_frames();
		send_frame(1'b0, 8'sh00, 1'b1);
		send_frame(1'b0, 8'sh00, 1'b0);
		send_frame(1'b0, 8'sh00, 1'b1);
		// Full scale sums of both signs on channel 0
		send_frame(1'b1, 8'sh80, 1'b0);
		send_frame(1'b1, 8'sh7f, 1'b1);
	endtask

	// Drain the output queue, then the end of run checks and summary
	task automatic drain_and_report();
		int waited;
		waited = 0;
		while (checker_i.pending != 0 && waited < DRAIN_TIMEOUT) begin
			idle_cycles(1);
			waited++;
		end
		// A few more cycles to catch any stray valid_out
		idle_cycles(8);
		if (checker_i.pending != 0) begin
			end_errors++;
			$display("Output stream did not drain in time, %0d expected values still queued",
				checker_i.pending);
		end
		if (checker_i.values_seen != FRAMES * FRAME_VALUES) begin
			end_errors++;
			$display("Saw %0d output values where %0d were expected",
				checker_i.values_seen, FRAMES * FRAME_VALUES);
		end
		$display("Error counts: %0d value, %0d protocol, %0d end of run",
			checker_i.value_errors, checker_i.other_errors, end_errors);
		if (checker_i.value_errors == 0 && checker_i.other_errors == 0 && end_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
	endtask

	initial begin
		int waited;
		weight_t value;
		clk          = 1'b0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_data  = '0;
		pixel_valid  = 1'b0;
		pixel_data   = '0;
		end_errors   = 0;
		void'($urandom(32'hd484));
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Extreme kernel on output channel 0 and random weights on channel 1
		for (int n = 0; n < WEIGHT_COUNT; n++) begin
			if (n < WEIGHT_COUNT / CHANNEL_NUM_OUT) begin
				value = 8'sh80;
			end else begin
				value = weight_t'($urandom);
			end
			send_weight(value);
			if ($urandom % 5 == 0) begin
				idle_cycles(1);
			end
		end
		waited = 0;
		while (!weights_loaded && waited < LOAD_TIMEOUT) begin
			idle_cycles(1);
			waited++;
		end

		//////////////////////////////
		// Frames
		//////////////////////////////
		if (!weights_loaded) begin
			$display("Timed out waiting for weights_loaded after the kernel load");
			$display("TESTBENCH FAILED");
		end else begin
			send_frames();
			drain_and_report();
		end
		$finish;
	end

endmodule
